// ==== include/exec_consts.svh ====
// Widths for operands, sequence numbers and register addresses
// Depth of the multiplier pipeline
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Operands, results and pc
`define DATA_W 32

// Tag carried by every micro-op
`define SEQ_NUM_BITS 5

// Register index, x0..x31
`define REG_ADDR_W 5

// ------------------------------
// Multiplier
// ------------------------------

// Register stages from accept to result
`define MUL_STAGES 3

`endif

// ==== src/uarch_pkg.sv ====
// Micro-op encoding seen by the execute stage
// Execute-unit select type and the uop-to-unit mapping
package uarch_pkg;

  // ------------------------------
  // Micro-ops
  // ------------------------------
  typedef enum logic [3:0] {
    uop_add  = 4'd0,
    uop_sub  = 4'd1,
    uop_and  = 4'd2,
    uop_or   = 4'd3,
    uop_xor  = 4'd4,
    uop_sll  = 4'd5,
    uop_srl  = 4'd6,
    uop_sra  = 4'd7,
    uop_slt  = 4'd8,
    uop_sltu = 4'd9,
    uop_mul  = 4'd10,
    uop_mulh = 4'd11
  } rv_uop;

  // Which peer unit executes a uop
  typedef enum logic {
    unit_alu = 1'b0,
    unit_mul = 1'b1
  } exec_unit_e;

  // Multiplies to the multiplier, everything else to the ALU
  function automatic exec_unit_e uop_unit(input rv_uop uop);
    exec_unit_e unit;
    unit = unit_alu;
    if (uop == uop_mul || uop == uop_mulh) begin
      unit = unit_mul;
    end
    return unit;
  endfunction

endpackage

// ==== src/msg_pkg.sv ====
// Message structs crossing the execute stage
// Decode-to-execute and execute-to-writeback payloads
`include "exec_consts.svh"

package msg_pkg;

  // ------------------------------
  // D to X
  // ------------------------------
  typedef struct packed {
    logic [`DATA_W-1:0]       pc;
    logic [`SEQ_NUM_BITS-1:0] seq_num;
    logic [`DATA_W-1:0]       op1;
    logic [`DATA_W-1:0]       op2;
    logic [`REG_ADDR_W-1:0]   waddr;
    uarch_pkg::rv_uop         uop;
  } dx_msg_t;

  // ------------------------------
  // X to W
  // ------------------------------
  // wen already cleared for x0 destinations
  typedef struct packed {
    logic [`DATA_W-1:0]       pc;
    logic [`SEQ_NUM_BITS-1:0] seq_num;
    logic [`REG_ADDR_W-1:0]   waddr;
    logic [`DATA_W-1:0]       wdata;
    logic                     wen;
  } xw_msg_t;

endpackage

// ==== src/exec_ifs.sv ====
// Decode-to-execute and execute-to-writeback val/rdy interfaces
// Source and destination modports for each
`include "exec_consts.svh"

// Micro-op channel into an execute unit
interface dx_if (
  input logic clk,
  input logic rst_n
);
  logic                     val;
  logic                     rdy;
  logic [`DATA_W-1:0]       pc;
  logic [`SEQ_NUM_BITS-1:0] seq_num;
  logic [`DATA_W-1:0]       op1;
  logic [`DATA_W-1:0]       op2;
  logic [`REG_ADDR_W-1:0]   waddr;
  uarch_pkg::rv_uop         uop;

  // Producer drives val and payload
  modport src (
    input  clk, rst_n, rdy,
    output val, pc, seq_num, op1, op2, waddr, uop
  );

  // Consumer answers with rdy
  modport dst (
    input  clk, rst_n, val, pc, seq_num, op1, op2, waddr, uop,
    output rdy
  );
endinterface

// Result channel toward writeback
interface xw_if (
  input logic clk,
  input logic rst_n
);
  logic                     val;
  logic                     rdy;
  logic [`DATA_W-1:0]       pc;
  logic [`SEQ_NUM_BITS-1:0] seq_num;
  logic [`REG_ADDR_W-1:0]   waddr;
  logic [`DATA_W-1:0]       wdata;
  logic                     wen;

  modport src (
    input  clk, rst_n, rdy,
    output val, pc, seq_num, waddr, wdata, wen
  );

  modport dst (
    input  clk, rst_n, val, pc, seq_num, waddr, wdata, wen,
    output rdy
  );
endinterface

// ==== src/issue_router.sv ====
// Issue router that steers each micro-op to the ALU or the multiplier
module issue_router (
  dx_if.dst in,
  dx_if.src alu,
  dx_if.src mul
);
  import uarch_pkg::*;

  exec_unit_e sel;

  // Target unit from the uop alone
  assign sel = uop_unit(in.uop);

  // val only toward the chosen unit
  assign alu.val = in.val && (sel == unit_alu);
  assign mul.val = in.val && (sel == unit_mul);

  // Upstream sees only the chosen unit's rdy
  assign in.rdy = (sel == unit_mul) ? mul.rdy : alu.rdy;

  // Payload fanned out to both units and qualified by val
  assign alu.pc      = in.pc;
  assign alu.seq_num = in.seq_num;
  assign alu.op1     = in.op1;
  assign alu.op2     = in.op2;
  assign alu.waddr   = in.waddr;
  assign alu.uop     = in.uop;

  assign mul.pc      = in.pc;
  assign mul.seq_num = in.seq_num;
  assign mul.op1     = in.op1;
  assign mul.op2     = in.op2;
  assign mul.waddr   = in.waddr;
  assign mul.uop     = in.uop;

  // A waiting op stays with exactly one unit until taken
  a_single_target: assert property (@(posedge in.clk) disable iff (!in.rst_n)
    (in.val && !in.rdy) |=> ((alu.val ^ mul.val) && $stable({alu.val, mul.val})));

endmodule

// ==== src/alu_unit.sv ====
// Single-cycle integer ALU
// One output register, held while writeback stalls
`include "exec_consts.svh"

module alu_unit (
  input  logic clk,
  input  logic rst_n,
  dx_if.dst    d,
  xw_if.src    w
);
  import uarch_pkg::*;
  import msg_pkg::*;

  localparam int SHAMT_W = $clog2(`DATA_W);

  logic               out_val;
  xw_msg_t            out_q;
  xw_msg_t            out_d;
  logic [`DATA_W-1:0] result;
  logic [SHAMT_W-1:0] shamt;
  logic               accept;

  // ------------------------------
  // Handshake
  // ------------------------------
  // Free when empty or draining this cycle
  assign d.rdy  = !out_val || w.rdy;
  assign accept = d.val && d.rdy;

  // ------------------------------
  // Compute
  // ------------------------------
  // Shift amount from low bits of op2
  assign shamt = d.op2[SHAMT_W-1:0];

  always_comb begin
    case (d.uop)
      uop_add:  result = d.op1 + d.op2;
      uop_sub:  result = d.op1 - d.op2;
      uop_and:  result = d.op1 & d.op2;
      uop_or:   result = d.op1 | d.op2;
      uop_xor:  result = d.op1 ^ d.op2;
      uop_sll:  result = d.op1 << shamt;
      uop_srl:  result = d.op1 >> shamt;
      uop_sra:  result = $signed(d.op1) >>> shamt;
      uop_slt:  result = {{(`DATA_W-1){1'b0}}, $signed(d.op1) < $signed(d.op2)};
      uop_sltu: result = {{(`DATA_W-1){1'b0}}, d.op1 < d.op2};
      // Multiplies never routed here
      default:  result = '0;
    endcase
  end

  // Result message, x0 never written
  always_comb begin
    out_d.pc      = d.pc;
    out_d.seq_num = d.seq_num;
    out_d.waddr   = d.waddr;
    out_d.wdata   = result;
    out_d.wen     = (d.waddr != '0);
  end

  // ------------------------------
  // Output register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_val <= 1'b0;
    end else if (accept) begin
      out_val <= 1'b1;
    end else if (w.rdy) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_q <= out_d;
    end
  end

  assign w.val     = out_val;
  assign w.pc      = out_q.pc;
  assign w.seq_num = out_q.seq_num;
  assign w.waddr   = out_q.waddr;
  assign w.wdata   = out_q.wdata;
  assign w.wen     = out_q.wen;

  // Stalled result held into the next cycle
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (w.val && !w.rdy) |=>
      (w.val && $stable({w.pc, w.seq_num, w.waddr, w.wdata, w.wen})));

endmodule

// ==== src/mul_unit.sv ====
// Pipelined signed multiplier, fixed depth
// Whole pipe freezes while its last stage is blocked
`include "exec_consts.svh"

module mul_unit (
  input  logic clk,
  input  logic rst_n,
  dx_if.dst    d,
  xw_if.src    w
);
  import uarch_pkg::*;

  localparam int LAST = `MUL_STAGES - 1;

  // Per-stage payload with the full 64-bit product
  typedef struct packed {
    logic [`DATA_W-1:0]       pc;
    logic [`SEQ_NUM_BITS-1:0] seq_num;
    logic [`REG_ADDR_W-1:0]   waddr;
    logic                     wen;
    logic                     hi;
    logic [2*`DATA_W-1:0]     prod;
  } mul_stage_t;

  logic [`MUL_STAGES-1:0] val_q;
  mul_stage_t             stage_q [`MUL_STAGES];
  mul_stage_t             stage_d;
  logic                   stall;

  // ------------------------------
  // Flow control
  // ------------------------------
  // Blocked result at the tail freezes everything
  assign stall = val_q[LAST] && !w.rdy;
  assign d.rdy = !stall;

  // Signed product formed on entry
  always_comb begin
    stage_d.pc      = d.pc;
    stage_d.seq_num = d.seq_num;
    stage_d.waddr   = d.waddr;
    stage_d.wen     = (d.waddr != '0);
    stage_d.hi      = (d.uop == uop_mulh);
    stage_d.prod    = $signed(d.op1) * $signed(d.op2);
  end

  // ------------------------------
  // Pipe registers
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_q <= '0;
    end else if (!stall) begin
      val_q[0] <= d.val;
      for (int i = 1; i < `MUL_STAGES; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      stage_q[0] <= stage_d;
      for (int i = 1; i < `MUL_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // ------------------------------
  // Output
  // ------------------------------
  assign w.val     = val_q[LAST];
  assign w.pc      = stage_q[LAST].pc;
  assign w.seq_num = stage_q[LAST].seq_num;
  assign w.waddr   = stage_q[LAST].waddr;
  assign w.wen     = stage_q[LAST].wen;
  // mulh takes the upper half
  assign w.wdata   = stage_q[LAST].hi ? stage_q[LAST].prod[2*`DATA_W-1:`DATA_W]
                                      : stage_q[LAST].prod[`DATA_W-1:0];

  // An accepted op always lands in the first stage, never lost to a stall
  a_no_take_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (d.val && d.rdy) |=> (val_q[0] && (stage_q[0].seq_num == $past(d.seq_num))));

endmodule

// ==== src/wb_arbiter.sv ====
// Round-robin arbiter merging ALU and multiplier results
// onto the single writeback bus
module wb_arbiter (
  input  logic clk,
  input  logic rst_n,
  xw_if.dst    alu,
  xw_if.dst    mul,
  xw_if.src    w
);
  logic last_mul;
  logic hold_q;
  logic hold_mul_q;
  logic grant_mul;
  logic grant_alu;

  // ------------------------------
  // Grant
  // ------------------------------
  // Stalled grant kept so w stays stable
  // otherwise the loser of the last transfer goes first
  assign grant_mul = hold_q ? hold_mul_q : (mul.val && (!alu.val || !last_mul));
  assign grant_alu = alu.val && !grant_mul;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_mul   <= 1'b0;
      hold_q     <= 1'b0;
      hold_mul_q <= 1'b0;
    end else begin
      hold_q     <= w.val && !w.rdy;
      hold_mul_q <= grant_mul;
      // Winner recorded on transfer only
      if (w.val && w.rdy) begin
        last_mul <= grant_mul;
      end
    end
  end

  // ------------------------------
  // Writeback mux
  // ------------------------------
  assign w.val     = alu.val || mul.val;
  assign w.pc      = grant_mul ? mul.pc      : alu.pc;
  assign w.seq_num = grant_mul ? mul.seq_num : alu.seq_num;
  assign w.waddr   = grant_mul ? mul.waddr   : alu.waddr;
  assign w.wdata   = grant_mul ? mul.wdata   : alu.wdata;
  assign w.wen     = grant_mul ? mul.wen     : alu.wen;

  // Loser keeps its result
  assign alu.rdy = grant_alu && w.rdy;
  assign mul.rdy = grant_mul && w.rdy;

  // Exactly one source gets rdy on a transfer, none otherwise
  a_one_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    (w.val && w.rdy) ? (alu.rdy ^ mul.rdy) : !(alu.rdy || mul.rdy));

endmodule

// ==== src/exec_top.sv ====
// Execute stage top level
// Plain D and W ports, router, ALU, multiplier and writeback arbiter
`include "exec_consts.svh"

module exec_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Decode side
  input  logic                     d_val,
  output logic                     d_rdy,
  input  logic [`DATA_W-1:0]       d_pc,
  input  logic [`SEQ_NUM_BITS-1:0] d_seq_num,
  input  logic [`DATA_W-1:0]       d_op1,
  input  logic [`DATA_W-1:0]       d_op2,
  input  logic [`REG_ADDR_W-1:0]   d_waddr,
  input  uarch_pkg::rv_uop         d_uop,
  // Writeback side
  output logic                     w_val,
  input  logic                     w_rdy,
  output logic [`DATA_W-1:0]       w_pc,
  output logic [`SEQ_NUM_BITS-1:0] w_seq_num,
  output logic [`REG_ADDR_W-1:0]   w_waddr,
  output logic [`DATA_W-1:0]       w_wdata,
  output logic                     w_wen
);

  // ------------------------------
  // Channels
  // ------------------------------
  dx_if d_x   (.clk(clk), .rst_n(rst_n));
  dx_if d_alu (.clk(clk), .rst_n(rst_n));
  dx_if d_mul (.clk(clk), .rst_n(rst_n));
  xw_if w_alu (.clk(clk), .rst_n(rst_n));
  xw_if w_mul (.clk(clk), .rst_n(rst_n));
  xw_if x_w   (.clk(clk), .rst_n(rst_n));

  // Decode ports onto the input channel
  assign d_x.val     = d_val;
  assign d_rdy       = d_x.rdy;
  assign d_x.pc      = d_pc;
  assign d_x.seq_num = d_seq_num;
  assign d_x.op1     = d_op1;
  assign d_x.op2     = d_op2;
  assign d_x.waddr   = d_waddr;
  assign d_x.uop     = d_uop;

  // Writeback channel out to ports
  assign w_val     = x_w.val;
  assign x_w.rdy   = w_rdy;
  assign w_pc      = x_w.pc;
  assign w_seq_num = x_w.seq_num;
  assign w_waddr   = x_w.waddr;
  assign w_wdata   = x_w.wdata;
  assign w_wen     = x_w.wen;

  // ------------------------------
  // Blocks
  // ------------------------------
  issue_router u_router (
    .in  (d_x),
    .alu (d_alu),
    .mul (d_mul)
  );

  alu_unit u_alu (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (d_alu),
    .w     (w_alu)
  );

  mul_unit u_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (d_mul),
    .w     (w_mul)
  );

  wb_arbiter u_arb (
    .clk   (clk),
    .rst_n (rst_n),
    .alu   (w_alu),
    .mul   (w_mul),
    .w     (x_w)
  );

endmodule

// ==== bench/exec_tb.sv ====
// Directed testbench for the execute stage
// Reference model, scoreboard by seq_num, compare tasks, cycle watchdog
`include "exec_consts.svh"

module exec_tb;
  import uarch_pkg::*;
  import msg_pkg::*;

  localparam int HALF = 20;
  localparam int BP_OPS = 120;
  localparam int CT_OPS = 48;
  // About 520 ops in all at roughly one cycle each plus drains
  localparam int MAX_CYCLES = 2000;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     d_val;
  logic                     d_rdy;
  logic [`DATA_W-1:0]       d_pc;
  logic [`SEQ_NUM_BITS-1:0] d_seq_num;
  logic [`DATA_W-1:0]       d_op1;
  logic [`DATA_W-1:0]       d_op2;
  logic [`REG_ADDR_W-1:0]   d_waddr;
  rv_uop                    d_uop;
  logic                     w_val;
  logic                     w_rdy;
  logic [`DATA_W-1:0]       w_pc;
  logic [`SEQ_NUM_BITS-1:0] w_seq_num;
  logic [`REG_ADDR_W-1:0]   w_waddr;
  logic [`DATA_W-1:0]       w_wdata;
  logic                     w_wen;

  // ------------------------------
  // Scoreboard state
  // ------------------------------
  xw_msg_t                  expected [2**`SEQ_NUM_BITS];
  logic                     pending [2**`SEQ_NUM_BITS];
  int                       accept_cycle [2**`SEQ_NUM_BITS];
  xw_msg_t                  seen_msg;
  int                       pending_count = 0;
  int                       retired_count = 0;
  int                       cycle_count = 0;
  int                       lat_limit = 0;
  int                       error_count = 0;
  int                       check_count = 0;
  int                       tests_run = 0;
  integer                   seed;
  logic [`DATA_W-1:0]       next_pc;
  logic [`SEQ_NUM_BITS-1:0] next_seq;
  logic                     rdy_random = 1'b0;
  logic [255:0]             rdy_pattern;
  logic [`DATA_W-1:0]       corners [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                            32'h8000_0000, 32'h7fff_ffff};

  exec_top UUT (.*);

  always #HALF clk = ~clk;

  // Back-pressure source driven on the falling edge
  always @(negedge clk) begin
    if (rdy_random) begin
      w_rdy = rdy_pattern[cycle_count[7:0]];
    end else begin
      w_rdy = 1'b1;
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic xw_msg_t model_msg(input rv_uop uop, input logic [`DATA_W-1:0] a,
                                        input logic [`DATA_W-1:0] b,
                                        input logic [`DATA_W-1:0] pc,
                                        input logic [`SEQ_NUM_BITS-1:0] seq,
                                        input logic [`REG_ADDR_W-1:0] waddr);
    xw_msg_t              m;
    logic [2*`DATA_W-1:0] wide_a;
    logic [2*`DATA_W-1:0] wide_b;
    logic [2*`DATA_W-1:0] wide;
    logic [4:0]           sh;
    // Low 64 bits of the sign-extended product give the signed product
    wide_a = {{`DATA_W{a[`DATA_W-1]}}, a};
    wide_b = {{`DATA_W{b[`DATA_W-1]}}, b};
    wide = wide_a * wide_b;
    sh = b[4:0];
    m.pc = pc;
    m.seq_num = seq;
    m.waddr = waddr;
    m.wen = (waddr != '0);
    case (uop)
      uop_add:  m.wdata = a + b;
      uop_sub:  m.wdata = a + ~b + 1'b1;
      uop_and:  m.wdata = a & b;
      uop_or:   m.wdata = a | b;
      uop_xor:  m.wdata = a ^ b;
      uop_sll:  m.wdata = a << sh;
      uop_srl:  m.wdata = a >> sh;
      uop_sra: begin
        wide = wide_a >> sh;
        m.wdata = wide[`DATA_W-1:0];
      end
      // When signs differ the negative one is less
      uop_slt:  m.wdata = {{(`DATA_W-1){1'b0}},
                           (a[`DATA_W-1] != b[`DATA_W-1]) ? a[`DATA_W-1] : (a < b)};
      uop_sltu: m.wdata = {{(`DATA_W-1){1'b0}}, (a < b)};
      uop_mul:  m.wdata = wide[`DATA_W-1:0];
      uop_mulh: m.wdata = wide[2*`DATA_W-1:`DATA_W];
      default:  m.wdata = '0;
    endcase
    return m;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_msg(input string name, input xw_msg_t got, input xw_msg_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Monitor samples one unit before each rising edge
  always begin
    @(negedge clk);
    #(HALF - 1);
    cycle_count++;
    if (rst_n) begin
      if (w_val && w_rdy) begin
        check_bit("w_seq_num in flight", pending[w_seq_num], 1'b1);
        if (pending[w_seq_num] === 1'b1) begin
          seen_msg.pc = w_pc;
          seen_msg.seq_num = w_seq_num;
          seen_msg.waddr = w_waddr;
          seen_msg.wdata = w_wdata;
          seen_msg.wen = w_wen;
          check_msg("w_msg", seen_msg, expected[w_seq_num]);
          if (lat_limit > 0 && cycle_count - accept_cycle[w_seq_num] > lat_limit) begin
            error_count++;
            $display("seq %0d waited %0d cycles for writeback with w_rdy high", w_seq_num,
                     cycle_count - accept_cycle[w_seq_num]);
          end
          pending[w_seq_num] = 1'b0;
          pending_count--;
          retired_count++;
        end
      end
      if (d_val && d_rdy) begin
        if (pending[d_seq_num] === 1'b1) begin
          error_count++;
          $display("seq %0d accepted again while still in flight", d_seq_num);
        end
        expected[d_seq_num] = model_msg(d_uop, d_op1, d_op2, d_pc, d_seq_num, d_waddr);
        pending[d_seq_num] = 1'b1;
        accept_cycle[d_seq_num] = cycle_count;
        pending_count++;
      end
    end
  end

  // ------------------------------
  // Driver helpers
  // ------------------------------
  // Starts just after a falling edge and returns on the falling edge after the transfer
  task automatic send_op(input rv_uop uop, input logic [`DATA_W-1:0] a,
                         input logic [`DATA_W-1:0] b, input logic [`REG_ADDR_W-1:0] waddr);
    logic taken;
    d_val = 1'b1;
    d_pc = next_pc;
    d_seq_num = next_seq;
    d_op1 = a;
    d_op2 = b;
    d_waddr = waddr;
    d_uop = uop;
    taken = 1'b0;
    while (!taken) begin
      #(HALF - 1);
      taken = d_rdy;
      @(negedge clk);
    end
    d_val = 1'b0;
    next_pc = next_pc + 32'd4;
    next_seq = next_seq + 1'b1;
  endtask

  task automatic drain();
    while (pending_count != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  function automatic logic [`REG_ADDR_W-1:0] dest(input int n);
    return `REG_ADDR_W'((n % 31) + 1);
  endfunction

  // All corner pairs then a few random pairs
  task automatic corner_sweep(input rv_uop uop);
    logic [`DATA_W-1:0] r1;
    logic [`DATA_W-1:0] r2;
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_op(uop, corners[i], corners[j], dest(i * 5 + j));
      end
    end
    repeat (4) begin
      r1 = $random(seed);
      r2 = $random(seed);
      send_op(uop, r1, r2, r1[4:0] | 5'd1);
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests_run++;
    $display("%s finished, %0d errors", name, error_count - errs_before);
  endtask

  task automatic count_results(input int base, input int n);
    if (retired_count - base != n) begin
      error_count++;
      $display("%0d results came back for %0d ops sent", retired_count - base, n);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic reset_check();
    int errs;
    errs = error_count;
    rst_n = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_bit("w_val", w_val, 1'b0);
    end
    rst_n = 1'b1;
    // Idle after reset with nothing sent
    repeat (5) begin
      @(negedge clk);
      check_bit("w_val", w_val, 1'b0);
    end
    report("reset_check", errs);
  endtask

  task automatic alu_ops();
    int errs;
    errs = error_count;
    for (int u = 0; u < 10; u++) begin
      corner_sweep(rv_uop'(u[3:0]));
    end
    drain();
    report("alu_ops", errs);
  endtask

  task automatic mul_ops();
    int errs;
    errs = error_count;
    corner_sweep(uop_mul);
    corner_sweep(uop_mulh);
    drain();
    report("mul_ops", errs);
  endtask

  // x0 destinations must come back with wen low
  task automatic x0_dest();
    int errs;
    errs = error_count;
    send_op(uop_add, 32'd5, 32'd6, 5'd0);
    send_op(uop_mul, 32'd3, 32'd4, 5'd0);
    send_op(uop_sub, 32'd1, 32'd2, 5'd0);
    send_op(uop_add, 32'd5, 32'd6, 5'd7);
    send_op(uop_mulh, 32'hffff_fff0, 32'd9, 5'd31);
    drain();
    report("x0_dest", errs);
  endtask

  task automatic back_pressure();
    int                 errs;
    int                 base;
    logic [`DATA_W-1:0] r;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    errs = error_count;
    // Ready about three cycles in four
    for (int i = 0; i < 256; i++) begin
      r = $random(seed);
      rdy_pattern[i] = (r[1:0] != 2'b00);
    end
    base = retired_count;
    rdy_random = 1'b1;
    for (int k = 0; k < BP_OPS; k++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      send_op(rv_uop'(r[3:0] % 4'd12), a, b, r[8:4]);
    end
    drain();
    rdy_random = 1'b0;
    count_results(base, BP_OPS);
    report("back_pressure", errs);
  endtask

  // Multiplies interleaved with ALU ops so both units meet at the arbiter
  task automatic contention();
    int                 errs;
    int                 base;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    errs = error_count;
    base = retired_count;
    lat_limit = 2 * `MUL_STAGES;
    for (int k = 0; k < CT_OPS; k++) begin
      a = $random(seed);
      b = $random(seed);
      if (k % 3 == 2) begin
        send_op(rv_uop'(4'(k % 10)), a, b, dest(k));
      end else begin
        send_op((k % 2 == 0) ? uop_mul : uop_mulh, a, b, dest(k));
      end
    end
    drain();
    lat_limit = 0;
    count_results(base, CT_OPS);
    report("contention", errs);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed = 32'hd8d8_8266;
    rst_n = 1'b0;
    d_val = 1'b0;
    d_pc = '0;
    d_seq_num = '0;
    d_op1 = '0;
    d_op2 = '0;
    d_waddr = '0;
    d_uop = uop_add;
    w_rdy = 1'b1;
    next_pc = 32'h0000_1000;
    next_seq = '0;
    for (int i = 0; i < 2**`SEQ_NUM_BITS; i++) begin
      pending[i] = 1'b0;
    end
    reset_check();
    alu_ops();
    mul_ops();
    x0_dest();
    back_pressure();
    contention();
    $display("%0d tests, %0d checks, %0d results, %0d errors", tests_run, check_count,
             retired_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog on the cycle counter
  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("Run stopped at cycle limit %0d with %0d results outstanding", MAX_CYCLES,
             pending_count);
    $display("test failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
src/uarch_pkg.sv
src/msg_pkg.sv
src/exec_ifs.sv
src/issue_router.sv
src/alu_unit.sv
src/mul_unit.sv
src/wb_arbiter.sv
src/exec_top.sv
bench/exec_tb.sv

// ==== Makefile ====
# Verilator simulation of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
